//--- project.f
+incdir+tests
verilog/gbe_pkg.sv
verilog/gbe_beat_fifo.sv
verilog/gbe_tx_framer.sv
verilog/gbe_rx_decode.sv
verilog/gbe_rx_result.sv
verilog/gbe_link_status.sv
verilog/gbe_fabric_core.sv
tests/tb_gbe_fabric_core.sv

//--- tests/tb_gbe_model.svh
`ifndef TB_GBE_MODEL_SVH
`define TB_GBE_MODEL_SVH

// Header with both MACs set to the node MAC
function automatic gbe_pkg::gbe_header_t make_header(
    input logic [15:0] ethertype,
    input logic [7:0]  ver_ihl,
    input logic [7:0]  protocol,
    input logic [31:0] source_ip,
    input logic [15:0] source_port,
    input logic [31:0] dest_ip,
    input logic [15:0] dest_port
);
    gbe_pkg::gbe_header_t h;
    h.dest_mac = gbe_pkg::fabric_mac;
    h.source_mac = gbe_pkg::fabric_mac;
    h.ethertype = ethertype;
    h.ver_ihl = ver_ihl;
    h.protocol = protocol;
    h.source_ip = source_ip;
    h.dest_ip = dest_ip;
    h.source_port = source_port;
    h.dest_port = dest_port;
    return h;
endfunction

// Header in the low bits, zeros above, never last
function automatic gbe_pkg::gbe_line_beat_t header_beat(input gbe_pkg::gbe_header_t h);
    gbe_pkg::gbe_line_beat_t b;
    b.data = '0;
    b.data[$bits(h)-1:0] = h;
    b.last = 1'b0;
    return b;
endfunction

// What the framer should send for a message
function automatic gbe_pkg::gbe_line_beat_t tx_header(
    input logic [31:0] dest_ip,
    input logic [15:0] dest_port
);
    return header_beat(make_header(gbe_pkg::ethertype_ipv4, gbe_pkg::ip_ver_ihl,
        gbe_pkg::ip_proto_udp, gbe_pkg::fabric_ip, gbe_pkg::fabric_port,
        dest_ip, dest_port));
endfunction

function automatic gbe_pkg::gbe_line_beat_t data_beat(
    input logic [gbe_pkg::data_width-1:0] data,
    input logic                           last
);
    gbe_pkg::gbe_line_beat_t b;
    b.data = data;
    b.last = last;
    return b;
endfunction

// Receive word carries the addresses of its frame header
function automatic gbe_pkg::gbe_rx_word_t rx_word_from(
    input gbe_pkg::gbe_header_t           h,
    input logic [gbe_pkg::data_width-1:0] data,
    input logic                           eof
);
    gbe_pkg::gbe_rx_word_t w;
    w.data = data;
    w.source_ip = h.source_ip;
    w.source_port = h.source_port;
    w.dest_ip = h.dest_ip;
    w.dest_port = h.dest_port;
    w.eof = eof;
    return w;
endfunction

`endif

//--- tests/tb_gbe_fabric_core.sv
`timescale 1ns/1ps

module tb_gbe_fabric_core;

    logic user_clk;
    logic reset;
    logic tx_valid;
    gbe_pkg::gbe_tx_word_t tx_word;
    logic tx_afull;
    logic tx_overflow;
    gbe_pkg::gbe_line_beat_t mac_tx;
    logic mac_tx_valid;
    logic mac_tx_ready;
    logic mac_rx_valid;
    gbe_pkg::gbe_line_beat_t mac_rx;
    logic mac_link_up;
    logic rx_valid;
    gbe_pkg::gbe_rx_word_t rx_word;
    logic rx_ack;
    logic rx_overrun;
    logic rx_overrun_ack;
    logic rx_bad_frame;
    logic led_up;
    logic led_rx;
    logic led_tx;

    // Injection side of the receive mux
    logic loopback;
    logic inj_valid;
    gbe_pkg::gbe_line_beat_t inj_beat;

    // 0 ready low, 1 ready high, 2 random
    int ready_mode;
    logic ack_enable;
    int seed;

    gbe_pkg::gbe_line_beat_t exp_tx_q[$];
    gbe_pkg::gbe_rx_word_t exp_rx_q[$];
    int exp_bad;
    int bad_seen;
    int ovf_seen;
    logic afull_seen;
    int tx_beats_seen;
    int errors;
    int checks;
    int beat_budget;
    int cycle_count;

    `include "tb_gbe_model.svh"

    gbe_fabric_core gbe_fabric_core_inst (
        .user_clk       (user_clk),
        .reset          (reset),
        .tx_valid       (tx_valid),
        .tx_word        (tx_word),
        .tx_afull       (tx_afull),
        .tx_overflow    (tx_overflow),
        .mac_tx         (mac_tx),
        .mac_tx_valid   (mac_tx_valid),
        .mac_tx_ready   (mac_tx_ready),
        .mac_rx_valid   (mac_rx_valid),
        .mac_rx         (mac_rx),
        .mac_link_up    (mac_link_up),
        .rx_valid       (rx_valid),
        .rx_word        (rx_word),
        .rx_ack         (rx_ack),
        .rx_overrun     (rx_overrun),
        .rx_overrun_ack (rx_overrun_ack),
        .rx_bad_frame   (rx_bad_frame),
        .led_up         (led_up),
        .led_rx         (led_rx),
        .led_tx         (led_tx)
    );

    // Loopback takes only beats the MAC accepted
    assign mac_rx_valid = loopback ? (mac_tx_valid && mac_tx_ready) : inj_valid;
    assign mac_rx = loopback ? mac_tx : inj_beat;

    always #2 user_clk = ~user_clk;

    task automatic check_value(input string name, input logic [639:0] expected,
                               input logic [639:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Advance to the next falling edge and refresh ready and ack
    task automatic step();
        logic [31:0] r;
        @(negedge user_clk);
        r = $random(seed);
        case (ready_mode)
            0: mac_tx_ready = 1'b0;
            1: mac_tx_ready = 1'b1;
            default: mac_tx_ready = r[0];
        endcase
        rx_ack = ack_enable && rx_valid;
    endtask

    function automatic logic [gbe_pkg::data_width-1:0] random_data();
        logic [gbe_pkg::data_width-1:0] d;
        for (int i = 0; i < gbe_pkg::data_width / 32; i++) begin
            d[i*32 +: 32] = $random(seed);
        end
        return d;
    endfunction

    // Send one user message and hold off each word while afull
    task automatic send_message(input int n_words, input logic [31:0] dest_ip,
                                input logic [15:0] dest_port, input bit delivered,
                                input bit rejected);
        gbe_pkg::gbe_header_t h;
        logic [gbe_pkg::data_width-1:0] d;
        h = make_header(gbe_pkg::ethertype_ipv4, gbe_pkg::ip_ver_ihl, gbe_pkg::ip_proto_udp,
            gbe_pkg::fabric_ip, gbe_pkg::fabric_port, dest_ip, dest_port);
        exp_tx_q.push_back(tx_header(dest_ip, dest_port));
        beat_budget += n_words + 1;
        if (rejected) begin
            exp_bad++;
        end
        for (int i = 0; i < n_words; i++) begin
            d = random_data();
            exp_tx_q.push_back(data_beat(d, i == n_words - 1));
            if (delivered) begin
                exp_rx_q.push_back(rx_word_from(h, d, i == n_words - 1));
            end
            tx_valid = 1'b0;
            while (tx_afull) begin
                step();
            end
            tx_valid = 1'b1;
            tx_word.data = d;
            tx_word.dest_ip = dest_ip;
            tx_word.dest_port = dest_port;
            tx_word.eof = (i == n_words - 1);
            step();
        end
        tx_valid = 1'b0;
    endtask

    // Inject a line frame and expect only its first keep words
    task automatic inject_frame(input gbe_pkg::gbe_header_t h, input int n_data,
                                input int keep, input bit rejected);
        logic [gbe_pkg::data_width-1:0] d;
        beat_budget += n_data + 1;
        if (rejected) begin
            exp_bad++;
        end
        inj_valid = 1'b1;
        inj_beat = header_beat(h);
        step();
        for (int i = 0; i < n_data; i++) begin
            d = random_data();
            inj_beat = data_beat(d, i == n_data - 1);
            if (i < keep) begin
                exp_rx_q.push_back(rx_word_from(h, d, i == n_data - 1));
            end
            step();
        end
        inj_valid = 1'b0;
    endtask

    task automatic wait_tx_done();
        while (exp_tx_q.size() != 0) begin
            step();
        end
    endtask

    // Drain both sides and let late strobes settle
    task automatic drain();
        wait_tx_done();
        while (exp_rx_q.size() != 0) begin
            step();
        end
        repeat (8) step();
        check_value("bad frame count", exp_bad, bad_seen);
    endtask

    // Transferred beats against model
    always @(posedge user_clk) begin
        if (!reset && mac_tx_valid && mac_tx_ready) begin
            tx_beats_seen++;
            if (exp_tx_q.size() == 0) begin
                errors++;
                $display("mac_tx sent a beat that the model did not expect");
            end else begin
                check_value("tx beat", exp_tx_q.pop_front(), mac_tx);
            end
        end
    end

    // Acked words against model
    always @(posedge user_clk) begin
        if (!reset && rx_valid && rx_ack) begin
            if (exp_rx_q.size() == 0) begin
                errors++;
                $display("rx_word delivered a word that the model did not expect");
            end else begin
                check_value("rx word", exp_rx_q.pop_front(), rx_word);
            end
        end
    end

    // Status strobes
    always @(posedge user_clk) begin
        if (!reset) begin
            if (rx_bad_frame) begin
                bad_seen++;
            end
            if (tx_overflow) begin
                ovf_seen++;
                if (!afull_seen) begin
                    errors++;
                    $display("tx_overflow pulsed before tx_afull was ever raised");
                end
            end
            if (tx_afull) begin
                afull_seen = 1'b1;
            end
        end
    end

    // Limit grows with the beats generated so far
    always @(posedge user_clk) begin
        cycle_count++;
        if (cycle_count > 64 * beat_budget + 2000) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        gbe_pkg::gbe_header_t h;
        user_clk = 1'b0;
        reset = 1'b1;
        tx_valid = 1'b0;
        tx_word = '0;
        mac_tx_ready = 1'b1;
        mac_link_up = 1'b0;
        rx_ack = 1'b0;
        rx_overrun_ack = 1'b0;
        loopback = 1'b0;
        inj_valid = 1'b0;
        inj_beat = '0;
        ready_mode = 1;
        ack_enable = 1'b0;
        seed = 32'h296d_aadf;
        exp_bad = 0;
        bad_seen = 0;
        ovf_seen = 0;
        afull_seen = 1'b0;
        tx_beats_seen = 0;
        errors = 0;
        checks = 0;
        beat_budget = 0;
        cycle_count = 0;

        repeat (5) step();
        reset = 1'b0;
        step();
        // Everything quiet out of reset
        check_value("reset state", 9'b0, {mac_tx_valid, tx_afull, tx_overflow, rx_valid,
            rx_bad_frame, rx_overrun, led_up, led_rx, led_tx});
        mac_link_up = 1'b1;
        ack_enable = 1'b1;

        // Framing with the MAC always ready
        for (int m = 0; m < 8; m++) begin
            r = $random(seed);
            send_message(1 + r[7:0] % 6, $random(seed), r[31:16], 1'b0, 1'b0);
        end
        wait_tx_done();
        check_value("led_tx after beats", 1'b1, led_tx);
        check_value("led_up", 1'b1, led_up);
        drain();

        // Loopback where odd messages miss our IP or port
        loopback = 1'b1;
        for (int m = 0; m < 10; m++) begin
            r = $random(seed);
            if (m % 2 == 0) begin
                send_message(1 + r[7:0] % 6, gbe_pkg::fabric_ip, gbe_pkg::fabric_port,
                    1'b1, 1'b0);
            end else if (m % 4 == 1) begin
                send_message(1 + r[7:0] % 6, gbe_pkg::fabric_ip ^ 32'h1,
                    gbe_pkg::fabric_port, 1'b0, 1'b1);
            end else begin
                send_message(1 + r[7:0] % 6, gbe_pkg::fabric_ip,
                    gbe_pkg::fabric_port + 16'd1, 1'b0, 1'b1);
            end
        end
        wait_tx_done();
        // Looped beats light the receive LED
        check_value("led_rx after loopback", 1'b1, led_rx);
        drain();

        // Malformed frames followed by a clean one
        loopback = 1'b0;
        h = make_header(16'h86dd, gbe_pkg::ip_ver_ihl, gbe_pkg::ip_proto_udp,
            32'h0a00_0017, 16'd4791, gbe_pkg::fabric_ip, gbe_pkg::fabric_port);
        inject_frame(h, 2, 0, 1'b1);
        h = make_header(gbe_pkg::ethertype_ipv4, gbe_pkg::ip_ver_ihl, 8'd6,
            32'h0a00_0017, 16'd4791, gbe_pkg::fabric_ip, gbe_pkg::fabric_port);
        inject_frame(h, 2, 0, 1'b1);
        h = make_header(gbe_pkg::ethertype_ipv4, 8'h46, gbe_pkg::ip_proto_udp,
            32'h0a00_0017, 16'd4791, gbe_pkg::fabric_ip, gbe_pkg::fabric_port);
        inject_frame(h, 2, 0, 1'b1);
        h = make_header(gbe_pkg::ethertype_ipv4, gbe_pkg::ip_ver_ihl, gbe_pkg::ip_proto_udp,
            32'h0a00_0017, 16'd4791, gbe_pkg::fabric_ip, gbe_pkg::fabric_port);
        inject_frame(h, 3, 3, 1'b0);
        drain();

        // MAC stalls about half the time
        loopback = 1'b1;
        ready_mode = 2;
        for (int m = 0; m < 12; m++) begin
            r = $random(seed);
            send_message(1 + r[7:0] % 6, gbe_pkg::fabric_ip, gbe_pkg::fabric_port,
                1'b1, 1'b0);
        end
        drain();
        ready_mode = 1;

        // Overrun keeps only the first queue-full of words
        loopback = 1'b0;
        ack_enable = 1'b0;
        inject_frame(h, 12, gbe_pkg::rx_fifo_depth, 1'b0);
        repeat (3) step();
        check_value("rx_overrun set", 1'b1, rx_overrun);
        ack_enable = 1'b1;
        drain();
        check_value("rx_overrun held", 1'b1, rx_overrun);
        rx_overrun_ack = 1'b1;
        step();
        rx_overrun_ack = 1'b0;
        check_value("rx_overrun cleared", 1'b0, rx_overrun);

        // Overflow with single-word messages into a stalled MAC
        ready_mode = 0;
        step();
        ovf_seen = 0;
        afull_seen = 1'b0;
        for (int i = 0; i < gbe_pkg::tx_fifo_depth + 4; i++) begin
            r = $random(seed);
            beat_budget += 2;
            tx_word.data = random_data();
            tx_word.dest_ip = r;
            tx_word.dest_port = r[15:0];
            tx_word.eof = 1'b1;
            if (i < gbe_pkg::tx_fifo_depth) begin
                exp_tx_q.push_back(tx_header(tx_word.dest_ip, tx_word.dest_port));
                exp_tx_q.push_back(data_beat(tx_word.data, 1'b1));
            end
            tx_valid = 1'b1;
            step();
        end
        tx_valid = 1'b0;
        repeat (2) step();
        check_value("overflow pulses", 4, ovf_seen);
        check_value("afull raised", 1'b1, afull_seen);
        r = tx_beats_seen;
        ready_mode = 1;
        drain();
        check_value("pushed words accounted", gbe_pkg::tx_fifo_depth + 4,
            ovf_seen + (tx_beats_seen - r) / 2);

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verilog/gbe_fabric_core.sv
`timescale 1ns/1ps

module gbe_fabric_core (
    input  logic                    user_clk,
    input  logic                    reset,
    // User transmit side
    input  logic                    tx_valid,
    input  gbe_pkg::gbe_tx_word_t   tx_word,
    output logic                    tx_afull,
    output logic                    tx_overflow,
    // Line transmit, toward the MAC
    output gbe_pkg::gbe_line_beat_t mac_tx,
    output logic                    mac_tx_valid,
    input  logic                    mac_tx_ready,
    // Line receive, no ready
    input  logic                    mac_rx_valid,
    input  gbe_pkg::gbe_line_beat_t mac_rx,
    input  logic                    mac_link_up,
    // User receive side
    output logic                    rx_valid,
    output gbe_pkg::gbe_rx_word_t   rx_word,
    input  logic                    rx_ack,
    output logic                    rx_overrun,
    input  logic                    rx_overrun_ack,
    output logic                    rx_bad_frame,
    // Front panel
    output logic                    led_up,
    output logic                    led_rx,
    output logic                    led_tx
);

    // Decode to result
    logic dec_valid;
    gbe_pkg::gbe_rx_word_t dec_word;
    // Activity toward the LEDs
    logic tx_beat_sent;
    logic rx_beat_seen;

    // Execute: framing toward the MAC
    gbe_tx_framer gbe_tx_framer_inst (
        .user_clk     (user_clk),
        .reset        (reset),
        .tx_valid     (tx_valid),
        .tx_word      (tx_word),
        .tx_afull     (tx_afull),
        .tx_overflow  (tx_overflow),
        .mac_tx       (mac_tx),
        .mac_tx_valid (mac_tx_valid),
        .mac_tx_ready (mac_tx_ready),
        .tx_beat_sent (tx_beat_sent)
    );

    // Decode: header check and filter
    gbe_rx_decode gbe_rx_decode_inst (
        .user_clk     (user_clk),
        .reset        (reset),
        .mac_rx_valid (mac_rx_valid),
        .mac_rx       (mac_rx),
        .dec_valid    (dec_valid),
        .dec_word     (dec_word),
        .rx_bad_frame (rx_bad_frame),
        .rx_beat_seen (rx_beat_seen)
    );

    // Result: queue toward the user
    gbe_rx_result gbe_rx_result_inst (
        .user_clk       (user_clk),
        .reset          (reset),
        .dec_valid      (dec_valid),
        .dec_word       (dec_word),
        .rx_ack         (rx_ack),
        .rx_overrun_ack (rx_overrun_ack),
        .rx_valid       (rx_valid),
        .rx_word        (rx_word),
        .rx_overrun     (rx_overrun)
    );

    gbe_link_status gbe_link_status_inst (
        .user_clk     (user_clk),
        .reset        (reset),
        .mac_link_up  (mac_link_up),
        .rx_beat_seen (rx_beat_seen),
        .tx_beat_sent (tx_beat_sent),
        .led_up       (led_up),
        .led_rx       (led_rx),
        .led_tx       (led_tx)
    );

endmodule

//--- verilog/gbe_link_status.sv
`timescale 1ns/1ps

module gbe_link_status (
    input  logic user_clk,
    input  logic reset,
    input  logic mac_link_up,
    input  logic rx_beat_seen,
    input  logic tx_beat_sent,
    output logic led_up,
    output logic led_rx,
    output logic led_tx
);

    // Two-flop sync of link state
    logic [1:0] link_sync;
    // Bit 0 receive, bit 1 transmit
    logic [1:0] activity;
    logic [gbe_pkg::led_count_width-1:0] hold_count [2];

    always_ff @(posedge user_clk) begin
        if (reset) begin
            link_sync <= '0;
        end else begin
            link_sync <= {link_sync[0], mac_link_up};
        end
    end

    assign led_up = link_sync[1];
    assign activity = {tx_beat_sent, rx_beat_seen};

    // Stretch each activity pulse so it is visible
    always_ff @(posedge user_clk) begin
        if (reset) begin
            hold_count[0] <= '0;
            hold_count[1] <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (activity[i]) begin
                    hold_count[i] <= gbe_pkg::led_hold_load;
                end else if (hold_count[i] != '0) begin
                    hold_count[i] <= hold_count[i] - 1'b1;
                end
            end
        end
    end

    assign led_rx = (hold_count[0] != '0);
    assign led_tx = (hold_count[1] != '0);

endmodule

//--- verilog/gbe_rx_result.sv
`timescale 1ns/1ps

module gbe_rx_result (
    input  logic                  user_clk,
    input  logic                  reset,
    input  logic                  dec_valid,
    input  gbe_pkg::gbe_rx_word_t dec_word,
    input  logic                  rx_ack,
    input  logic                  rx_overrun_ack,
    output logic                  rx_valid,
    output gbe_pkg::gbe_rx_word_t rx_word,
    output logic                  rx_overrun
);

    logic fifo_push;
    logic fifo_empty;
    logic fifo_full;

    // A full queue drops the word since the line has no ready
    assign fifo_push = dec_valid && !fifo_full;

    gbe_beat_fifo #(
        .payload_t (gbe_pkg::gbe_rx_word_t),
        .depth     (gbe_pkg::rx_fifo_depth)
    ) rx_fifo_inst (
        .user_clk  (user_clk),
        .reset     (reset),
        .push      (fifo_push),
        .push_data (dec_word),
        .pop       (rx_ack),
        .head      (rx_word),
        .empty     (fifo_empty),
        .full      (fifo_full),
        .count     ()
    );

    // Level while a word waits at the head
    assign rx_valid = !fifo_empty;

    // Sticky overrun where a new drop wins over the clear
    always_ff @(posedge user_clk) begin
        if (reset) begin
            rx_overrun <= 1'b0;
        end else if (dec_valid && fifo_full) begin
            rx_overrun <= 1'b1;
        end else if (rx_overrun_ack) begin
            rx_overrun <= 1'b0;
        end
    end

    // User acks only a presented word
    ack_with_word: assert property (@(posedge user_clk) disable iff (reset)
        rx_ack |-> rx_valid)
        else $error("gbe_rx_result: rx_ack with empty queue");

endmodule

//--- verilog/gbe_rx_decode.sv
`timescale 1ns/1ps

module gbe_rx_decode (
    input  logic                    user_clk,
    input  logic                    reset,
    input  logic                    mac_rx_valid,
    input  gbe_pkg::gbe_line_beat_t mac_rx,
    output logic                    dec_valid,
    output gbe_pkg::gbe_rx_word_t   dec_word,
    output logic                    rx_bad_frame,
    output logic                    rx_beat_seen
);

    // Next beat starts a frame
    logic expect_header;
    // Current frame was rejected
    logic discard;

    gbe_pkg::gbe_header_t rx_header;
    logic header_ok;

    // Header lives in the low bits of the first beat
    assign rx_header = mac_rx.data[gbe_pkg::header_width-1:0];

    // IPv4/UDP to our IP and port
    assign header_ok = (rx_header.ethertype == gbe_pkg::ethertype_ipv4)
                    && (rx_header.ver_ihl == gbe_pkg::ip_ver_ihl)
                    && (rx_header.protocol == gbe_pkg::ip_proto_udp)
                    && (rx_header.dest_ip == gbe_pkg::fabric_ip)
                    && (rx_header.dest_port == gbe_pkg::fabric_port);

    // Frame tracking and strobes
    always_ff @(posedge user_clk) begin
        if (reset) begin
            expect_header <= 1'b1;
            discard <= 1'b0;
            dec_valid <= 1'b0;
            rx_bad_frame <= 1'b0;
            rx_beat_seen <= 1'b0;
        end else begin
            dec_valid <= 1'b0;
            rx_bad_frame <= 1'b0;
            // Activity for the LED
            rx_beat_seen <= mac_rx_valid;
            if (mac_rx_valid) begin
                // A frame always ends on last
                expect_header <= mac_rx.last;
                if (expect_header) begin
                    rx_bad_frame <= !header_ok;
                    discard <= !header_ok;
                end else begin
                    dec_valid <= !discard;
                end
            end
        end
    end

    // Word payload
    always_ff @(posedge user_clk) begin
        if (mac_rx_valid) begin
            if (expect_header) begin
                // Addresses held for the rest of the frame
                dec_word.source_ip <= rx_header.source_ip;
                dec_word.source_port <= rx_header.source_port;
                dec_word.dest_ip <= rx_header.dest_ip;
                dec_word.dest_port <= rx_header.dest_port;
            end else begin
                dec_word.data <= mac_rx.data;
                dec_word.eof <= mac_rx.last;
            end
        end
    end

endmodule

//--- verilog/gbe_tx_framer.sv
`timescale 1ns/1ps

module gbe_tx_framer (
    input  logic                    user_clk,
    input  logic                    reset,
    input  logic                    tx_valid,
    input  gbe_pkg::gbe_tx_word_t   tx_word,
    output logic                    tx_afull,
    output logic                    tx_overflow,
    output gbe_pkg::gbe_line_beat_t mac_tx,
    output logic                    mac_tx_valid,
    input  logic                    mac_tx_ready,
    output logic                    tx_beat_sent
);

    // Header beat first, then data beats until eof
    typedef enum logic {
        st_header,
        st_data
    } state_t;

    state_t state;

    gbe_pkg::gbe_tx_word_t head_word;
    logic fifo_push;
    logic fifo_pop;
    logic fifo_empty;
    logic fifo_full;
    logic [gbe_pkg::tx_count_width-1:0] fifo_count;

    // Output register can take a new beat
    logic out_free;

    gbe_pkg::gbe_header_t header;
    gbe_pkg::gbe_line_beat_t header_beat;

    // Words arriving on a full queue are lost
    assign fifo_push = tx_valid && !fifo_full;

    gbe_beat_fifo #(
        .payload_t (gbe_pkg::gbe_tx_word_t),
        .depth     (gbe_pkg::tx_fifo_depth)
    ) tx_fifo_inst (
        .user_clk  (user_clk),
        .reset     (reset),
        .push      (fifo_push),
        .push_data (tx_word),
        .pop       (fifo_pop),
        .head      (head_word),
        .empty     (fifo_empty),
        .full      (fifo_full),
        .count     (fifo_count)
    );

    // User-facing status flags
    always_ff @(posedge user_clk) begin
        if (reset) begin
            tx_overflow <= 1'b0;
            tx_afull <= 1'b0;
        end else begin
            tx_overflow <= tx_valid && fifo_full;
            tx_afull <= (fifo_count >= gbe_pkg::tx_afull_level);
        end
    end

    // Header for the message at the queue head
    always_comb begin
        header.dest_mac = gbe_pkg::fabric_mac;
        header.source_mac = gbe_pkg::fabric_mac;
        header.ethertype = gbe_pkg::ethertype_ipv4;
        header.ver_ihl = gbe_pkg::ip_ver_ihl;
        header.protocol = gbe_pkg::ip_proto_udp;
        header.source_ip = gbe_pkg::fabric_ip;
        header.dest_ip = head_word.dest_ip;
        header.source_port = gbe_pkg::fabric_port;
        header.dest_port = head_word.dest_port;
        // Zero padding above the header
        header_beat.data = '0;
        header_beat.data[gbe_pkg::header_width-1:0] = header;
        header_beat.last = 1'b0;
    end

    assign out_free = !mac_tx_valid || mac_tx_ready;
    // One word leaves the queue per data beat loaded
    assign fifo_pop = out_free && (state == st_data) && !fifo_empty;

    // FSM and valid
    always_ff @(posedge user_clk) begin
        if (reset) begin
            state <= st_header;
            mac_tx_valid <= 1'b0;
        end else if (out_free) begin
            // Valid drops when queue runs dry mid-message
            mac_tx_valid <= !fifo_empty;
            if (!fifo_empty) begin
                if (state == st_header) begin
                    state <= st_data;
                end else if (head_word.eof) begin
                    state <= st_header;
                end
            end
        end
    end

    // Beat register, held while MAC stalls
    always_ff @(posedge user_clk) begin
        if (out_free && !fifo_empty) begin
            if (state == st_header) begin
                mac_tx <= header_beat;
            end else begin
                mac_tx.data <= head_word.data;
                mac_tx.last <= head_word.eof;
            end
        end
    end

    assign tx_beat_sent = mac_tx_valid && mac_tx_ready;

    // Stalled beat must not move or vanish
    beat_held: assert property (@(posedge user_clk) disable iff (reset)
        mac_tx_valid && !mac_tx_ready |=> mac_tx_valid && $stable(mac_tx))
        else $error("gbe_tx_framer: beat changed under back-pressure");

endmodule

//--- verilog/gbe_beat_fifo.sv
`timescale 1ns/1ps

module gbe_beat_fifo #(
    parameter type payload_t = logic,
    parameter int depth = 16
) (
    input  logic                         user_clk,
    input  logic                         reset,
    input  logic                         push,
    input  payload_t                     push_data,
    input  logic                         pop,
    output payload_t                     head,
    output logic                         empty,
    output logic                         full,
    output logic [$clog2(depth+1)-1:0]   count
);

    // Word storage
    payload_t mem [depth];

    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;

    // Write side
    always_ff @(posedge user_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge user_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                // Wrap at the last slot so any depth works
                wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head is visible with no read latency
    assign head = mem[rd_ptr];
    assign empty = (count == 0);
    assign full = (count == depth);

    // Callers own flow control
    push_not_full: assert property (@(posedge user_clk) disable iff (reset)
        push |-> !full)
        else $error("gbe_beat_fifo: push while full");

    pop_not_empty: assert property (@(posedge user_clk) disable iff (reset)
        pop |-> !empty)
        else $error("gbe_beat_fifo: pop while empty");

endmodule

//--- verilog/gbe_pkg.sv
package gbe_pkg;

    // Payload bits per beat, user and line side alike
    localparam int data_width = 512;

    // Node identity
    localparam logic [47:0] fabric_mac = 48'hff_ff_ff_ff_ff_ff;
    // 192.168.5.200
    localparam logic [31:0] fabric_ip = 32'hc0a8_05c8;
    localparam logic [15:0] fabric_port = 16'd10000;

    // Header field values we send and accept
    localparam logic [15:0] ethertype_ipv4 = 16'h0800;
    localparam logic [7:0] ip_proto_udp = 8'd17;
    localparam logic [7:0] ip_ver_ihl = 8'h45;

    // Queue sizes in words
    localparam int tx_fifo_depth = 16;
    localparam int tx_afull_margin = 4;
    localparam int rx_fifo_depth = 8;
    localparam int tx_count_width = $clog2(tx_fifo_depth + 1);
    // Almost-full threshold on transmit occupancy
    localparam logic [tx_count_width-1:0] tx_afull_level =
        tx_count_width'(tx_fifo_depth - tx_afull_margin);

    // LED stretch length in cycles
    localparam int led_hold_cycles = 16;
    localparam int led_count_width = $clog2(led_hold_cycles + 1);
    localparam logic [led_count_width-1:0] led_hold_load = led_count_width'(led_hold_cycles);

    // Frame header, sits in the low bits of the header beat
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] source_mac;
        logic [15:0] ethertype;
        logic [7:0]  ver_ihl;
        logic [7:0]  protocol;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
    } gbe_header_t;

    localparam int header_width = $bits(gbe_header_t);

    // One beat on the line-side streams
    typedef struct packed {
        logic [data_width-1:0] data;
        logic                  last;
    } gbe_line_beat_t;

    // User transmit word
    typedef struct packed {
        logic [data_width-1:0] data;
        logic [31:0]           dest_ip;
        logic [15:0]           dest_port;
        logic                  eof;
    } gbe_tx_word_t;

    // User receive word, addresses taken from the frame header
    typedef struct packed {
        logic [data_width-1:0] data;
        logic [31:0]           source_ip;
        logic [15:0]           source_port;
        logic [31:0]           dest_ip;
        logic [15:0]           dest_port;
        logic                  eof;
    } gbe_rx_word_t;

endpackage
